// ==== verilog/pmu_pkg.sv ====
`default_nettype none

package pmu_pkg;

    // ------------------------------
    // Register word
    // ------------------------------

    // Width of a register word and of every counter
    localparam int REG_WIDTH = 32;
    typedef logic [REG_WIDTH-1:0] reg_word_t;

    // Word address of the register map
    localparam int ADDR_WIDTH = 4;
    typedef logic [ADDR_WIDTH-1:0] reg_addr_t;

    // ------------------------------
    // Main configuration register
    // ------------------------------

    // Counter bank enable and soft reset
    localparam int CFG_CNT_EN = 0;
    localparam int CFG_CNT_SOFTRST = 1;
    // Overflow capture enable and soft reset
    localparam int CFG_OVF_EN = 2;
    localparam int CFG_OVF_SOFTRST = 3;
    // Quota pass restart
    localparam int CFG_QUOTA_SOFTRST = 4;
    // Two bit self-test field in bits 31:30
    localparam int CFG_SELFTEST_LSB = 30;

    // Event override applied after the crossbar
    typedef enum logic [1:0] {
        ST_NONE    = 2'b00,
        ST_ALL_ON  = 2'b01,
        ST_ALL_OFF = 2'b10,
        ST_ONE_ON  = 2'b11
    } selftest_e;

    // Quota pass, one counter per cycle in Q_ACCUM
    typedef enum logic [1:0] {
        Q_CLEAR   = 2'b00,
        Q_ACCUM   = 2'b01,
        Q_COMPARE = 2'b10
    } quota_state_e;

endpackage

`default_nettype wire

// ==== verilog/pmu_regs.sv ====
`default_nettype none
`timescale 1ns/1ns

module pmu_regs #(
    parameter int N_COUNTERS = 9,
    parameter int N_SOC_EV = 32,
    localparam int SEL_W = $clog2(N_SOC_EV),
    localparam int IDX_W = $clog2(N_COUNTERS)
) (
    input  wire                       clk_i,
    input  wire                       rstn_i,
    input  wire                       wr_en_i,
    input  wire pmu_pkg::reg_addr_t   wr_addr_i,
    input  wire pmu_pkg::reg_word_t   wr_data_i,
    input  wire pmu_pkg::reg_addr_t   rd_addr_i,
    input  wire pmu_pkg::reg_word_t   cnt_value_i [N_COUNTERS],
    input  wire [N_COUNTERS-1:0]      ovf_vect_i,
    output pmu_pkg::reg_word_t        rd_data_o,
    output logic                      cnt_en_o,
    output logic                      cnt_softrst_o,
    output logic                      ovf_en_o,
    output logic                      ovf_softrst_o,
    output logic                      quota_softrst_o,
    output pmu_pkg::selftest_e        selftest_o,
    output logic [SEL_W-1:0]          xbar_sel_o [N_COUNTERS],
    output logic [N_COUNTERS-1:0]     ovf_mask_o,
    output logic [N_COUNTERS-1:0]     quota_mask_o,
    output pmu_pkg::reg_word_t        quota_limit_o,
    output logic                      cnt_load_o,
    output logic [IDX_W-1:0]          cnt_load_idx_o,
    output pmu_pkg::reg_word_t        cnt_load_data_o
);

    // ------------------------------
    // Memory map
    // ------------------------------

    // Config word, then counters, then overflow, quota and crossbar words
    localparam pmu_pkg::reg_addr_t ADDR_CFG = pmu_pkg::reg_addr_t'(0);
    localparam pmu_pkg::reg_addr_t BASE_CNT = pmu_pkg::reg_addr_t'(1);
    localparam pmu_pkg::reg_addr_t END_CNT = pmu_pkg::reg_addr_t'(N_COUNTERS);
    localparam pmu_pkg::reg_addr_t ADDR_OVF_MASK = pmu_pkg::reg_addr_t'(N_COUNTERS + 1);
    localparam pmu_pkg::reg_addr_t ADDR_OVF_VECT = pmu_pkg::reg_addr_t'(N_COUNTERS + 2);
    localparam pmu_pkg::reg_addr_t ADDR_QUOTA_MASK = pmu_pkg::reg_addr_t'(N_COUNTERS + 3);
    localparam pmu_pkg::reg_addr_t ADDR_QUOTA_LIMIT = pmu_pkg::reg_addr_t'(N_COUNTERS + 4);
    localparam pmu_pkg::reg_addr_t BASE_XBAR = pmu_pkg::reg_addr_t'(N_COUNTERS + 5);
    // Select fields are packed across word boundaries
    localparam int N_XBAR_REGS = (N_COUNTERS * SEL_W - 1) / pmu_pkg::REG_WIDTH + 1;

    pmu_pkg::reg_word_t cfg_q;
    logic [N_COUNTERS-1:0] ovf_mask_q;
    logic [N_COUNTERS-1:0] quota_mask_q;
    pmu_pkg::reg_word_t quota_limit_q;
    pmu_pkg::reg_word_t xbar_q [N_XBAR_REGS];
    logic [N_XBAR_REGS*pmu_pkg::REG_WIDTH-1:0] xbar_flat;
    logic wr_in_cnt;
    logic rd_in_cnt;
    logic [IDX_W-1:0] rd_idx;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q <= '0;
            ovf_mask_q <= '0;
            quota_mask_q <= '0;
            quota_limit_q <= '0;
            for (int i = 0; i < N_XBAR_REGS; i++) begin
                xbar_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            // Overflow vector and counters are owned elsewhere
            if (wr_addr_i == ADDR_CFG) begin
                cfg_q <= wr_data_i;
            end
            if (wr_addr_i == ADDR_OVF_MASK) begin
                ovf_mask_q <= wr_data_i[N_COUNTERS-1:0];
            end
            if (wr_addr_i == ADDR_QUOTA_MASK) begin
                quota_mask_q <= wr_data_i[N_COUNTERS-1:0];
            end
            if (wr_addr_i == ADDR_QUOTA_LIMIT) begin
                quota_limit_q <= wr_data_i;
            end
            for (int i = 0; i < N_XBAR_REGS; i++) begin
                if (wr_addr_i == pmu_pkg::reg_addr_t'(BASE_XBAR + i)) begin
                    xbar_q[i] <= wr_data_i;
                end
            end
        end
    end

    // Config fields
    assign cnt_en_o = cfg_q[pmu_pkg::CFG_CNT_EN];
    assign cnt_softrst_o = cfg_q[pmu_pkg::CFG_CNT_SOFTRST];
    assign ovf_en_o = cfg_q[pmu_pkg::CFG_OVF_EN];
    assign ovf_softrst_o = cfg_q[pmu_pkg::CFG_OVF_SOFTRST];
    assign quota_softrst_o = cfg_q[pmu_pkg::CFG_QUOTA_SOFTRST];
    assign selftest_o = pmu_pkg::selftest_e'(cfg_q[pmu_pkg::CFG_SELFTEST_LSB +: 2]);
    assign ovf_mask_o = ovf_mask_q;
    assign quota_mask_o = quota_mask_q;
    assign quota_limit_o = quota_limit_q;

    // Flatten the crossbar words, then cut one select per counter
    always_comb begin
        for (int i = 0; i < N_XBAR_REGS; i++) begin
            xbar_flat[i*pmu_pkg::REG_WIDTH +: pmu_pkg::REG_WIDTH] = xbar_q[i];
        end
        for (int c = 0; c < N_COUNTERS; c++) begin
            xbar_sel_o[c] = xbar_flat[c*SEL_W +: SEL_W];
        end
    end

    // ------------------------------
    // Counter preload
    // ------------------------------

    assign wr_in_cnt = (wr_addr_i >= BASE_CNT) && (wr_addr_i <= END_CNT);
    assign cnt_load_o = wr_en_i && wr_in_cnt;
    assign cnt_load_idx_o = IDX_W'(wr_addr_i - BASE_CNT);
    assign cnt_load_data_o = wr_data_i;

    // ------------------------------
    // Readback
    // ------------------------------

    assign rd_in_cnt = (rd_addr_i >= BASE_CNT) && (rd_addr_i <= END_CNT);
    assign rd_idx = IDX_W'(rd_addr_i - BASE_CNT);

    always_comb begin
        // Unmapped addresses read as zero
        rd_data_o = '0;
        if (rd_addr_i == ADDR_CFG) begin
            rd_data_o = cfg_q;
        end else if (rd_in_cnt) begin
            rd_data_o = cnt_value_i[rd_idx];
        end else if (rd_addr_i == ADDR_OVF_MASK) begin
            rd_data_o = pmu_pkg::reg_word_t'(ovf_mask_q);
        end else if (rd_addr_i == ADDR_OVF_VECT) begin
            rd_data_o = pmu_pkg::reg_word_t'(ovf_vect_i);
        end else if (rd_addr_i == ADDR_QUOTA_MASK) begin
            rd_data_o = pmu_pkg::reg_word_t'(quota_mask_q);
        end else if (rd_addr_i == ADDR_QUOTA_LIMIT) begin
            rd_data_o = quota_limit_q;
        end
        for (int i = 0; i < N_XBAR_REGS; i++) begin
            if (rd_addr_i == pmu_pkg::reg_addr_t'(BASE_XBAR + i)) begin
                rd_data_o = xbar_q[i];
            end
        end
    end

    // A load must land on an existing counter in the bank
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        cnt_load_o |-> (cnt_load_idx_o < N_COUNTERS));

endmodule

`default_nettype wire

// ==== verilog/pmu_event_route.sv ====
`default_nettype none
`timescale 1ns/1ns

module pmu_event_route #(
    parameter int N_COUNTERS = 9,
    parameter int N_SOC_EV = 32,
    localparam int SEL_W = $clog2(N_SOC_EV)
) (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire [N_SOC_EV-1:0]       events_i,
    input  wire [SEL_W-1:0]          xbar_sel_i [N_COUNTERS],
    input  wire pmu_pkg::selftest_e  selftest_i,
    output logic [N_COUNTERS-1:0]    cnt_events_o
);

    // ------------------------------
    // Crossbar
    // ------------------------------

    // One registered event line per counter
    logic [N_COUNTERS-1:0] routed_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            routed_q <= '0;
        end else begin
            for (int c = 0; c < N_COUNTERS; c++) begin
                routed_q[c] <= events_i[xbar_sel_i[c]];
            end
        end
    end

    // ------------------------------
    // Self-test override
    // ------------------------------

    always_comb begin
        case (selftest_i)
            pmu_pkg::ST_ALL_ON: begin
                cnt_events_o = '1;
            end
            pmu_pkg::ST_ALL_OFF: begin
                cnt_events_o = '0;
            end
            // Only counter 0 sees an event
            pmu_pkg::ST_ONE_ON: begin
                cnt_events_o = N_COUNTERS'(1);
            end
            default: begin
                cnt_events_o = routed_q;
            end
        endcase
    end

    // All-off mode silences every counter input
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (selftest_i == pmu_pkg::ST_ALL_OFF) |-> (cnt_events_o == '0));

endmodule

`default_nettype wire

// ==== verilog/pmu_counters.sv ====
`default_nettype none
`timescale 1ns/1ns

module pmu_counters #(
    parameter int N_COUNTERS = 9,
    localparam int IDX_W = $clog2(N_COUNTERS)
) (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire                      en_i,
    input  wire                      softrst_i,
    input  wire [N_COUNTERS-1:0]     events_i,
    input  wire                      load_i,
    input  wire [IDX_W-1:0]          load_idx_i,
    input  wire pmu_pkg::reg_word_t  load_data_i,
    output pmu_pkg::reg_word_t       value_o [N_COUNTERS]
);

    // High while any counter holds a non-zero value
    logic cnt_any_set;

    // ------------------------------
    // Counter bank
    // ------------------------------

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                value_o[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                // Software preload wins over soft reset and counting
                if (load_i && (load_idx_i == IDX_W'(i))) begin
                    value_o[i] <= load_data_i;
                end else if (softrst_i) begin
                    value_o[i] <= '0;
                end else if (en_i && events_i[i]) begin
                    value_o[i] <= value_o[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        cnt_any_set = 1'b0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            cnt_any_set = cnt_any_set | (|value_o[i]);
        end
    end

    // A soft reset cycle without a preload leaves the whole bank cleared
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (softrst_i && !load_i) |=> !cnt_any_set);

endmodule

`default_nettype wire

// ==== verilog/pmu_overflow.sv ====
`default_nettype none
`timescale 1ns/1ns

module pmu_overflow #(
    parameter int N_COUNTERS = 9
) (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire                      en_i,
    input  wire                      softrst_i,
    input  wire pmu_pkg::reg_word_t  cnt_value_i [N_COUNTERS],
    input  wire [N_COUNTERS-1:0]     mask_i,
    output logic [N_COUNTERS-1:0]    vect_o,
    output logic                     intr_overflow_o
);

    // Counters sitting at all ones this cycle
    logic [N_COUNTERS-1:0] at_max;

    always_comb begin
        for (int i = 0; i < N_COUNTERS; i++) begin
            at_max[i] = &cnt_value_i[i];
        end
    end

    // Sticky vector, only cleared by the soft reset
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vect_o <= '0;
        end else if (softrst_i) begin
            vect_o <= '0;
        end else if (en_i) begin
            vect_o <= vect_o | at_max;
        end
    end

    assign intr_overflow_o = |(vect_o & mask_i);

    // Interrupt rises after an enabled capture or a mask update
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(intr_overflow_o) |-> (|(vect_o & mask_i))
            && ($past(en_i) || $changed(mask_i)));

endmodule

`default_nettype wire

// ==== verilog/pmu_quota.sv ====
`default_nettype none
`timescale 1ns/1ns

module pmu_quota #(
    parameter int N_COUNTERS = 9,
    localparam int IDX_W = $clog2(N_COUNTERS)
) (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire                      softrst_i,
    input  wire pmu_pkg::reg_word_t  cnt_value_i [N_COUNTERS],
    input  wire [N_COUNTERS-1:0]     mask_i,
    input  wire pmu_pkg::reg_word_t  limit_i,
    output logic                     intr_quota_o
);

    pmu_pkg::quota_state_e state_q;
    pmu_pkg::reg_word_t sum_q;
    logic [IDX_W-1:0] idx_q;

    // ------------------------------
    // Masked sum FSM
    // ------------------------------

    // One pass is N_COUNTERS+2 cycles
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= pmu_pkg::Q_CLEAR;
            sum_q <= '0;
            idx_q <= '0;
            intr_quota_o <= 1'b0;
        end else if (softrst_i) begin
            // Drop the interrupt and restart the pass
            state_q <= pmu_pkg::Q_CLEAR;
            sum_q <= '0;
            idx_q <= '0;
            intr_quota_o <= 1'b0;
        end else begin
            case (state_q)
                pmu_pkg::Q_CLEAR: begin
                    sum_q <= '0;
                    idx_q <= '0;
                    state_q <= pmu_pkg::Q_ACCUM;
                end
                pmu_pkg::Q_ACCUM: begin
                    if (mask_i[idx_q]) begin
                        sum_q <= sum_q + cnt_value_i[idx_q];
                    end
                    if (idx_q == IDX_W'(N_COUNTERS - 1)) begin
                        state_q <= pmu_pkg::Q_COMPARE;
                    end else begin
                        idx_q <= idx_q + 1'b1;
                    end
                end
                pmu_pkg::Q_COMPARE: begin
                    // Sticky until the quota soft reset
                    if (sum_q > limit_i) begin
                        intr_quota_o <= 1'b1;
                    end
                    state_q <= pmu_pkg::Q_CLEAR;
                end
                default: begin
                    state_q <= pmu_pkg::Q_CLEAR;
                end
            endcase
        end
    end

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q == pmu_pkg::Q_ACCUM) |-> (idx_q < N_COUNTERS));

endmodule

`default_nettype wire

// ==== verilog/pmu_top.sv ====
`default_nettype none
`timescale 1ns/1ns

module pmu_top #(
    parameter int N_COUNTERS = 9,
    parameter int N_SOC_EV = 32
) (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire                      wr_en_i,
    input  wire pmu_pkg::reg_addr_t  wr_addr_i,
    input  wire pmu_pkg::reg_word_t  wr_data_i,
    input  wire pmu_pkg::reg_addr_t  rd_addr_i,
    input  wire [N_SOC_EV-1:0]       events_i,
    output pmu_pkg::reg_word_t       rd_data_o,
    output logic                     intr_overflow_o,
    output logic                     intr_quota_o
);

    localparam int SEL_W = $clog2(N_SOC_EV);
    localparam int IDX_W = $clog2(N_COUNTERS);

    // ------------------------------
    // Config fields
    // ------------------------------

    logic cnt_en;
    logic cnt_softrst;
    logic ovf_en;
    logic ovf_softrst;
    logic quota_softrst;
    pmu_pkg::selftest_e selftest;
    logic [SEL_W-1:0] xbar_sel [N_COUNTERS];
    logic [N_COUNTERS-1:0] ovf_mask;
    logic [N_COUNTERS-1:0] quota_mask;
    pmu_pkg::reg_word_t quota_limit;

    // Preload path into the counter bank
    logic cnt_load;
    logic [IDX_W-1:0] cnt_load_idx;
    pmu_pkg::reg_word_t cnt_load_data;

    // Datapath between the blocks
    logic [N_COUNTERS-1:0] cnt_events;
    pmu_pkg::reg_word_t cnt_value [N_COUNTERS];
    logic [N_COUNTERS-1:0] ovf_vect;

    pmu_regs #(
        .N_COUNTERS (N_COUNTERS),
        .N_SOC_EV   (N_SOC_EV)
    ) u_regs (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .wr_en_i         (wr_en_i),
        .wr_addr_i       (wr_addr_i),
        .wr_data_i       (wr_data_i),
        .rd_addr_i       (rd_addr_i),
        .cnt_value_i     (cnt_value),
        .ovf_vect_i      (ovf_vect),
        .rd_data_o       (rd_data_o),
        .cnt_en_o        (cnt_en),
        .cnt_softrst_o   (cnt_softrst),
        .ovf_en_o        (ovf_en),
        .ovf_softrst_o   (ovf_softrst),
        .quota_softrst_o (quota_softrst),
        .selftest_o      (selftest),
        .xbar_sel_o      (xbar_sel),
        .ovf_mask_o      (ovf_mask),
        .quota_mask_o    (quota_mask),
        .quota_limit_o   (quota_limit),
        .cnt_load_o      (cnt_load),
        .cnt_load_idx_o  (cnt_load_idx),
        .cnt_load_data_o (cnt_load_data)
    );

    pmu_event_route #(
        .N_COUNTERS (N_COUNTERS),
        .N_SOC_EV   (N_SOC_EV)
    ) u_event_route (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .events_i     (events_i),
        .xbar_sel_i   (xbar_sel),
        .selftest_i   (selftest),
        .cnt_events_o (cnt_events)
    );

    pmu_counters #(
        .N_COUNTERS (N_COUNTERS)
    ) u_counters (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .en_i        (cnt_en),
        .softrst_i   (cnt_softrst),
        .events_i    (cnt_events),
        .load_i      (cnt_load),
        .load_idx_i  (cnt_load_idx),
        .load_data_i (cnt_load_data),
        .value_o     (cnt_value)
    );

    pmu_overflow #(
        .N_COUNTERS (N_COUNTERS)
    ) u_overflow (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .en_i            (ovf_en),
        .softrst_i       (ovf_softrst),
        .cnt_value_i     (cnt_value),
        .mask_i          (ovf_mask),
        .vect_o          (ovf_vect),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_quota #(
        .N_COUNTERS (N_COUNTERS)
    ) u_quota (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .softrst_i    (quota_softrst),
        .cnt_value_i  (cnt_value),
        .mask_i       (quota_mask),
        .limit_i      (quota_limit),
        .intr_quota_o (intr_quota_o)
    );

endmodule

`default_nettype wire

// ==== sim/pmu_tb.sv ====
`default_nettype none
`timescale 1ns/1ns

module pmu_tb;

    localparam int N_COUNTERS = 9;
    localparam int N_SOC_EV = 32;
    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 5;
    localparam int WATCHDOG_CYCLES_PER_LINE = 50;
    localparam logic [31:0] RAND_SEED = 32'h5920_d51c;
    localparam TRACE_PATH = "sim/pmu_trace.txt";
    // Lines 16 and up are never selected by the trace, so they carry noise
    localparam logic [N_SOC_EV-1:0] NOISE_MASK = 32'hFFFF_0000;

    logic clk_i;
    logic rstn_i;
    logic wr_en_i;
    pmu_pkg::reg_addr_t wr_addr_i;
    pmu_pkg::reg_word_t wr_data_i;
    pmu_pkg::reg_addr_t rd_addr_i;
    logic [N_SOC_EV-1:0] events_i;
    pmu_pkg::reg_word_t rd_data_o;
    logic intr_overflow_o;
    logic intr_quota_o;

    // Per-test and total bookkeeping
    int trace_lines = 0;
    int test_checks = 0;
    int test_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int total_checks = 0;
    int total_errors = 0;
    bit test_open = 0;
    string test_name = "";

    pmu_top #(
        .N_COUNTERS (N_COUNTERS),
        .N_SOC_EV   (N_SOC_EV)
    ) uut (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .wr_en_i         (wr_en_i),
        .wr_addr_i       (wr_addr_i),
        .wr_data_i       (wr_data_i),
        .rd_addr_i       (rd_addr_i),
        .events_i        (events_i),
        .rd_data_o       (rd_data_o),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ------------------------------
    // Checks
    // ------------------------------

    task automatic check_word(input pmu_pkg::reg_addr_t addr, input pmu_pkg::reg_word_t got,
                              input pmu_pkg::reg_word_t exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("CHECK FAILED at %0t ns: address %0d read 0x%08h, expected 0x%08h",
                     $time, addr, got, exp);
        end
    endtask

    task automatic check_intr(input string which, input logic got, input logic exp);
        test_checks++;
        if (got !== exp) begin
            test_errors++;
            $display("CHECK FAILED at %0t ns: interrupt %s is %b, expected %b",
                     $time, which, got, exp);
        end
    endtask

    // Trace problems, not wrong values
    task automatic report_error(input string msg);
        test_errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    // Fold the current test into the totals and print its line
    task automatic close_test();
        if (test_open) begin
            tests_run++;
            if (test_errors == 0) begin
                $display("Test %-20s ok     (%0d checks)", test_name, test_checks);
            end else begin
                tests_failed++;
                $display("Test %-20s FAILED (%0d of %0d checks wrong)",
                         test_name, test_errors, test_checks);
            end
        end
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
        test_open = 0;
    endtask

    task automatic open_test(input string name);
        close_test();
        test_name = name;
        test_open = 1;
    endtask

    // ------------------------------
    // Bus and event drivers
    // ------------------------------

    // All driving starts right after a falling edge and ends on one
    task automatic write_reg(input pmu_pkg::reg_addr_t addr, input pmu_pkg::reg_word_t data);
        wr_en_i = 1'b1;
        wr_addr_i = addr;
        wr_data_i = data;
        @(negedge clk_i);
        wr_en_i = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
    endtask

    // One line high for a number of rising edges, noise on the upper half
    task automatic hold_event(input int line, input int cycles);
        logic [N_SOC_EV-1:0] noise;
        repeat (cycles) begin
            noise = N_SOC_EV'($urandom());
            events_i = (noise & NOISE_MASK) | (N_SOC_EV'(1) << line);
            @(negedge clk_i);
        end
        events_i = '0;
    endtask

    // Read port is combinational, sampled well before the next rising edge
    task automatic read_expect(input pmu_pkg::reg_addr_t addr, input pmu_pkg::reg_word_t exp);
        rd_addr_i = addr;
        #1;
        check_word(addr, rd_data_o, exp);
        @(negedge clk_i);
    endtask

    function automatic logic intr_level(input string which);
        if (which == "O") begin
            return intr_overflow_o;
        end else begin
            return intr_quota_o;
        end
    endfunction

    // Wait up to bound cycles for the expected level
    task automatic expect_intr(input string which, input logic level, input int bound);
        int waited;
        logic seen;
        waited = 0;
        #1;
        seen = intr_level(which);
        while (seen !== level && waited < bound) begin
            @(negedge clk_i);
            #1;
            seen = intr_level(which);
            waited++;
        end
        check_intr(which, seen, level);
        @(negedge clk_i);
    endtask

    // ------------------------------
    // Trace runner
    // ------------------------------

    initial begin
        int fd;
        int status;
        int n_lines;
        int unsigned a0;
        int unsigned a1;
        int unsigned seed_out;
        string line;
        string cmd;
        string arg_s;

        clk_i = 1'b0;
        rstn_i = 1'b0;
        wr_en_i = 1'b0;
        wr_addr_i = '0;
        wr_data_i = '0;
        rd_addr_i = '0;
        events_i = '0;
        seed_out = $urandom(RAND_SEED);

        // First pass only sizes the watchdog
        n_lines = 0;
        fd = $fopen(TRACE_PATH, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                if (status > 0) begin
                    n_lines++;
                end
            end
            $fclose(fd);
        end
        trace_lines = n_lines;

        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn_i = 1'b1;

        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            report_error($sformatf("could not open the trace file %s", TRACE_PATH));
        end else begin
            while (!$feof(fd)) begin
                line = "";
                status = $fgets(line, fd);
                if (status <= 0) begin
                    continue;
                end
                status = $sscanf(line, "%s", cmd);
                // Blank lines and comments
                if (status < 1 || cmd.substr(0, 0) == "#") begin
                    continue;
                end
                case (cmd)
                    "T": begin
                        status = $sscanf(line, "%s %s", cmd, arg_s);
                        open_test(arg_s);
                    end
                    "W": begin
                        status = $sscanf(line, "%s %h %h", cmd, a0, a1);
                        if (status != 3) begin
                            report_error($sformatf("malformed write line: %s", line));
                        end else begin
                            write_reg(pmu_pkg::reg_addr_t'(a0), pmu_pkg::reg_word_t'(a1));
                        end
                    end
                    "E": begin
                        status = $sscanf(line, "%s %d %d", cmd, a0, a1);
                        if (status != 3 || a0 >= 16) begin
                            report_error($sformatf("malformed event line: %s", line));
                        end else begin
                            hold_event(a0, a1);
                        end
                    end
                    "N": begin
                        status = $sscanf(line, "%s %d", cmd, a0);
                        repeat (a0) @(negedge clk_i);
                    end
                    "R": begin
                        status = $sscanf(line, "%s %h %h", cmd, a0, a1);
                        if (status != 3) begin
                            report_error($sformatf("malformed read line: %s", line));
                        end else begin
                            read_expect(pmu_pkg::reg_addr_t'(a0), pmu_pkg::reg_word_t'(a1));
                        end
                    end
                    "I": begin
                        status = $sscanf(line, "%s %s %d %d", cmd, arg_s, a0, a1);
                        if (status != 4 || !(arg_s == "O" || arg_s == "Q")) begin
                            report_error($sformatf("malformed interrupt line: %s", line));
                        end else begin
                            expect_intr(arg_s, a0[0], a1);
                        end
                    end
                    default: begin
                        report_error($sformatf("unknown trace command: %s", line));
                    end
                endcase
            end
            $fclose(fd);
        end

        close_test();
        $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the trace length
    initial begin
        wait (trace_lines > 0);
        repeat (WATCHDOG_CYCLES_PER_LINE * trace_lines) @(posedge clk_i);
        $display("Timeout: the trace did not finish within %0d cycles",
                 WATCHDOG_CYCLES_PER_LINE * trace_lines);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/pmu_trace.txt ====
# Columns: command then fields, W and R numbers in hex, E N and I numbers in decimal
# T name | W addr data | E line cycles | N cycles | R addr expect | I O|Q level max_cycles
T defaults_readback
I O 0 0
I Q 0 0
R 0 0
R 1 0
R 2 0
R 3 0
R 4 0
R 5 0
R 6 0
R 7 0
R 8 0
R 9 0
R A 0
R B 0
R C 0
R D 0
R E 0
R F 0
W A 1A5
R A 1A5
W C F3
R C F3
W D DEADBEEF
R D DEADBEEF
W E 89ABCDEF
R E 89ABCDEF
W F 12345678
R F 12345678
# Overflow vector is read-only
W B FFFFFFFF
R B 0
W A 0
W C 0
W D 0
W E 0
W F 0
T xbar_soft_reset
# Counter 0 on event 5, counter 1 on event 7
W E E5
W F 0
W 0 1
E 5 10
N 2
R 1 A
R 2 0
W 0 3
W 0 0
R 1 0
R 2 0
T selftest_modes
# All on, enable held for 6 edges
W 0 40000000
W 0 40000001
N 5
W 0 40000000
R 1 6
R 2 6
R 5 6
R 9 6
# One on, 4 edges
W 0 C0000000
W 0 C0000001
N 3
W 0 C0000000
R 1 A
R 2 6
R 9 6
# All off, nothing moves
W 0 80000000
W 0 80000001
N 3
W 0 80000000
R 1 A
R 2 6
R 9 6
W 0 2
W 0 0
R 1 0
R 9 0
T preload_overflow
W 4 FFFFFFFF
W 0 4
N 2
R B 8
I O 0 0
W A 8
I O 1 2
R 4 FFFFFFFF
W 0 C
W 0 0
R B 0
I O 0 0
W 4 0
W A 0
T quota_interrupt
# Limit first so no pass sees a partial setup
W D 64
W 1 28
W 2 46
W C 3
I Q 1 22
W 0 10
W D C8
W 0 0
I Q 0 0
N 22
I Q 0 0
R D C8

// ==== flist.f ====
verilog/pmu_pkg.sv
verilog/pmu_regs.sv
verilog/pmu_event_route.sv
verilog/pmu_counters.sv
verilog/pmu_overflow.sv
verilog/pmu_quota.sv
verilog/pmu_top.sv
sim/pmu_tb.sv
